/* hw/uop_pkg.sv */
// ==========================================================================
// Shared types and constants for the micro-op cracking core.
// Every block pulls these in through a wildcard import.
// ==========================================================================

package uop_pkg;

	// ======================================================================
	// Sizes and register convention
	// ======================================================================
	localparam int XLEN    = 32;
	localparam int NREGS   = 16;
	localparam int REG_W   = 4;
	localparam int UOP_MAX = 5;
	localparam int CNT_W   = 3;
	// Instruction immediate and the widened micro-op immediate
	localparam int IIMM_W  = 12;
	localparam int IMM_W   = 13;

	// r14 carries the carry bit, r15 is scratch for carry chains
	localparam logic [REG_W-1:0] CARRY_REG = 4'd14;
	localparam logic [REG_W-1:0] TEMP_REG  = 4'd15;

	// ======================================================================
	// Opcodes
	// ======================================================================
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,
		OP_ADD = 4'd1,
		OP_SUB = 4'd2,
		OP_AND = 4'd3,
		OP_OR  = 4'd4,
		OP_XOR = 4'd5,
		OP_MOV = 4'd6,
		OP_LDI = 4'd7,
		OP_CMP = 4'd8
	} op_e;

	typedef enum logic [3:0] {
		UOP_NOP   = 4'd0,
		UOP_ADD   = 4'd1,
		UOP_SUB   = 4'd2,
		UOP_AND   = 4'd3,
		UOP_OR    = 4'd4,
		UOP_XOR   = 4'd5,
		UOP_MOV   = 4'd6,
		// Carry out of a+b, as 0 or 1
		UOP_AGC   = 4'd7,
		// Carry out of a+b ORed into rd
		UOP_AGCOR = 4'd8,
		// Flags only, no write
		UOP_CMP   = 4'd9
	} uop_op_e;

	// ======================================================================
	// Instruction and micro-op formats
	// ======================================================================
	// Opcode sits in the top nibble, immediate in the low bits
	typedef struct packed {
		op_e                opcode;
		logic [REG_W-1:0]   rd;
		logic [REG_W-1:0]   rs1;
		logic [REG_W-1:0]   rs2;
		logic               rec;
		logic               cin;
		logic               cout;
		logic               imm_en;
		logic [IIMM_W-1:0]  imm;
	} instr_t;

	typedef struct packed {
		uop_op_e            op;
		logic [REG_W-1:0]   rd;
		logic [REG_W-1:0]   ra;
		logic [REG_W-1:0]   rb;
		logic               use_imm;
		logic [IMM_W-1:0]   imm;
		logic               wr;
		logic               last;
	} uop_t;

	typedef uop_t [UOP_MAX-1:0] uop_list_t;

	// Condition flags from a signed compare
	typedef struct packed {
		logic lt;
		logic eq;
		logic gt;
	} cr_t;

	typedef struct packed {
		uop_op_e            op;
		logic [REG_W-1:0]   rd;
		logic               wr;
		logic [XLEN-1:0]    value;
		cr_t                flags;
		logic               last;
	} res_t;

	// Filler entry for unused list slots
	localparam uop_t UOP_IDLE = '{op: UOP_NOP, default: '0};

endpackage

/* hw/uop_expand.sv */
// ==========================================================================
// Combinational cracker that turns one instruction into a list of up to
// UOP_MAX micro-ops plus the number of valid entries.
// ==========================================================================

module uop_expand import uop_pkg::*; (
	input  instr_t          instr,
	output uop_list_t       uop_list,
	output logic [CNT_W-1:0] count
);

	logic [CNT_W-1:0] n;
	logic [IMM_W-1:0] imm_x;
	logic             wr_op;

	// Builds one entry, last is patched in afterwards
	function automatic uop_t mk_uop(
		input uop_op_e          op,
		input logic [REG_W-1:0] rd,
		input logic [REG_W-1:0] ra,
		input logic [REG_W-1:0] rb,
		input logic             use_imm,
		input logic [IMM_W-1:0] imm,
		input logic             wr
	);
		uop_t u;
		u = UOP_IDLE;
		u.op = op;
		u.rd = rd;
		u.ra = ra;
		u.rb = rb;
		u.use_imm = use_imm;
		u.imm = imm;
		u.wr = wr;
		return u;
	endfunction

	// Sign extend the instruction immediate by one bit
	assign imm_x = {instr.imm[IIMM_W-1], instr.imm};

	// Opcodes that write rd and so may carry a record compare
	assign wr_op = (instr.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
		OP_MOV, OP_LDI});

	always_comb
	begin
		for (int i = 0; i < UOP_MAX; i++)
			uop_list[i] = UOP_IDLE;
		n = 3'd1;
		case (instr.opcode)
			OP_ADD:
			begin
				case ({instr.cin, instr.cout})
					2'b10:
					begin
						// TEMP = rs1 + C, then rd = TEMP + b
						uop_list[0] = mk_uop(UOP_ADD, TEMP_REG, instr.rs1, CARRY_REG,
							1'b0, '0, 1'b1);
						uop_list[1] = mk_uop(UOP_ADD, instr.rd, TEMP_REG, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
						n = 3'd2;
					end
					2'b01:
					begin
						// Carry is generated before rd can alias a source
						uop_list[0] = mk_uop(UOP_AGC, CARRY_REG, instr.rs1, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
						uop_list[1] = mk_uop(UOP_ADD, instr.rd, instr.rs1, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
						n = 3'd2;
					end
					2'b11:
					begin
						// Full carry chain through the scratch register
						uop_list[0] = mk_uop(UOP_ADD, TEMP_REG, instr.rs1, CARRY_REG,
							1'b0, '0, 1'b1);
						uop_list[1] = mk_uop(UOP_AGC, CARRY_REG, instr.rs1, CARRY_REG,
							1'b0, '0, 1'b1);
						uop_list[2] = mk_uop(UOP_AGCOR, CARRY_REG, TEMP_REG, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
						uop_list[3] = mk_uop(UOP_ADD, instr.rd, TEMP_REG, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
						n = 3'd4;
					end
					default:
						uop_list[0] = mk_uop(UOP_ADD, instr.rd, instr.rs1, instr.rs2,
							instr.imm_en, imm_x, 1'b1);
				endcase
			end
			OP_SUB:
				uop_list[0] = mk_uop(UOP_SUB, instr.rd, instr.rs1, instr.rs2,
					instr.imm_en, imm_x, 1'b1);
			OP_AND:
				uop_list[0] = mk_uop(UOP_AND, instr.rd, instr.rs1, instr.rs2,
					instr.imm_en, imm_x, 1'b1);
			OP_OR:
				uop_list[0] = mk_uop(UOP_OR, instr.rd, instr.rs1, instr.rs2,
					instr.imm_en, imm_x, 1'b1);
			OP_XOR:
				uop_list[0] = mk_uop(UOP_XOR, instr.rd, instr.rs1, instr.rs2,
					instr.imm_en, imm_x, 1'b1);
			OP_MOV:
				uop_list[0] = mk_uop(UOP_MOV, instr.rd, instr.rs1, instr.rs2,
					1'b0, '0, 1'b1);
			// Load immediate is a move with the immediate selected
			OP_LDI:
				uop_list[0] = mk_uop(UOP_MOV, instr.rd, instr.rs1, instr.rs2,
					1'b1, imm_x, 1'b1);
			OP_CMP:
				uop_list[0] = mk_uop(UOP_CMP, instr.rd, instr.rs1, instr.rs2,
					instr.imm_en, imm_x, 1'b0);
			default:
				uop_list[0] = UOP_IDLE;
		endcase
		// Record form compares the result against zero
		if (instr.rec && wr_op)
		begin
			uop_list[n] = mk_uop(UOP_CMP, instr.rd, instr.rd, instr.rs2, 1'b1, '0, 1'b0);
			n = n + 1'b1;
		end
		uop_list[n - 1'b1].last = 1'b1;
		count = n;
	end

endmodule

/* hw/uop_sequencer.sv */
// ==========================================================================
// Front end sequencer. Takes one instruction at a time, cracks it and
// issues its micro-ops in order over the issue handshake.
// ==========================================================================

module uop_sequencer import uop_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	// Instruction input
	input  logic   in_valid,
	output logic   in_ready,
	input  instr_t in_instr,
	// Micro-op issue
	output logic   iss_valid,
	input  logic   iss_ready,
	output uop_t   iss_uop
);

	instr_t           ir_q;
	logic             held_q;
	logic [CNT_W-1:0] idx_q;
	uop_list_t        list;
	logic [CNT_W-1:0] count;
	logic             in_xfer;
	logic             iss_xfer;
	logic             iss_final;

	// ======================================================================
	// Cracking of the held instruction
	// ======================================================================
	uop_expand u_uop_expand (
		.instr    (ir_q),
		.uop_list (list),
		.count    (count)
	);

	// Input is only open when nothing is held
	assign in_ready  = !held_q;
	assign in_xfer   = in_valid && in_ready;

	assign iss_valid = held_q;
	assign iss_uop   = list[idx_q];
	assign iss_xfer  = iss_valid && iss_ready;

	// Entry count-1 is the one that carries last
	assign iss_final = (idx_q == count - 1'b1);

	// ======================================================================
	// Hold flag and list index
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			held_q <= 1'b0;
			idx_q  <= '0;
		end
		else if (in_xfer)
		begin
			held_q <= 1'b1;
			idx_q  <= '0;
		end
		else if (iss_xfer)
		begin
			// Release the input once the final entry has gone
			if (iss_final)
				held_q <= 1'b0;
			else
				idx_q <= idx_q + 1'b1;
		end
	end

	// Instruction payload
	always_ff @(posedge clk)
	begin
		if (in_xfer)
			ir_q <= in_instr;
	end

endmodule

/* hw/uop_alu.sv */
// ==========================================================================
// Integer execute stage. Reads the register file, computes one micro-op
// combinationally and writes back on the result transfer.
// ==========================================================================

module uop_alu import uop_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	// Micro-op issue
	input  logic iss_valid,
	output logic iss_ready,
	input  uop_t iss_uop,
	// Result to retire
	output logic exe_valid,
	input  logic exe_ready,
	output res_t exe_res
);

	logic [XLEN-1:0] rf [NREGS];
	logic [XLEN-1:0] a;
	logic [XLEN-1:0] b;
	logic [XLEN-1:0] d;
	logic [XLEN:0]   sum;
	logic [XLEN-1:0] diff;
	logic [XLEN-1:0] carry;
	logic [XLEN-1:0] value;
	cr_t             cmp;
	logic            exe_xfer;

	// ======================================================================
	// Operand fetch
	// ======================================================================
	assign a = rf[iss_uop.ra];
	// Immediate is sign extended to full width
	assign b = iss_uop.use_imm ?
		{{(XLEN-IMM_W){iss_uop.imm[IMM_W-1]}}, iss_uop.imm} : rf[iss_uop.rb];
	// Old destination value, needed by AGCOR
	assign d = rf[iss_uop.rd];

	assign sum   = {1'b0, a} + {1'b0, b};
	assign diff  = a - b;
	assign carry = XLEN'(sum[XLEN]);

	// Signed compare, handed to retire in the flags field
	assign cmp.lt = ($signed(a) < $signed(b));
	assign cmp.eq = (a == b);
	assign cmp.gt = ($signed(a) > $signed(b));

	// ======================================================================
	// Arithmetic
	// ======================================================================
	always_comb
	begin
		case (iss_uop.op)
			UOP_ADD:   value = sum[XLEN-1:0];
			UOP_SUB:   value = diff;
			UOP_AND:   value = a & b;
			UOP_OR:    value = a | b;
			UOP_XOR:   value = a ^ b;
			// Move takes the immediate when it is selected
			UOP_MOV:   value = iss_uop.use_imm ? b : a;
			UOP_AGC:   value = carry;
			UOP_AGCOR: value = d | carry;
			UOP_CMP:   value = diff;
			default:   value = '0;
		endcase
	end

	// Handshake passes straight through, no storage here
	assign exe_valid = iss_valid;
	assign iss_ready = exe_ready;
	assign exe_xfer  = exe_valid && exe_ready;

	always_comb
	begin
		exe_res       = '0;
		exe_res.op    = iss_uop.op;
		exe_res.rd    = iss_uop.rd;
		exe_res.wr    = iss_uop.wr;
		exe_res.value = value;
		exe_res.last  = iss_uop.last;
		if (iss_uop.op == UOP_CMP)
			exe_res.flags = cmp;
	end

	// Write back on transfer so the next micro-op sees the new value
	always_ff @(posedge clk)
	begin
		if (rst_n && exe_xfer && iss_uop.wr)
			rf[iss_uop.rd] <= value;
	end

endmodule

/* hw/uop_retire.sv */
// ==========================================================================
// Retire stage. One output register plus the condition flag register,
// stamped onto every record it presents.
// ==========================================================================

module uop_retire import uop_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	// From execute
	input  logic exe_valid,
	output logic exe_ready,
	input  res_t exe_res,
	// Output port
	output logic out_valid,
	input  logic out_ready,
	output res_t out_res
);

	cr_t  cr_q;
	cr_t  cr_nxt;
	logic exe_xfer;

	// Accept when empty or when the held record leaves this cycle
	assign exe_ready = !out_valid || out_ready;
	assign exe_xfer  = exe_valid && exe_ready;

	// Only a compare changes the flags
	assign cr_nxt = (exe_res.op == UOP_CMP) ? exe_res.flags : cr_q;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			cr_q      <= '0;
		end
		else if (exe_xfer)
		begin
			out_valid <= 1'b1;
			cr_q      <= cr_nxt;
		end
		else if (out_ready)
			out_valid <= 1'b0;
	end

	// Record payload with the flags as they stand after this micro-op
	always_ff @(posedge clk)
	begin
		if (exe_xfer)
		begin
			out_res       <= exe_res;
			out_res.flags <= cr_nxt;
		end
	end

endmodule

/* hw/uop_core.sv */
// ==========================================================================
// Core top level. Sequencer, execute and retire joined by valid/ready
// links; instructions in, one record per micro-op out.
// ==========================================================================

module uop_core import uop_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	// Instruction input
	input  logic   in_valid,
	output logic   in_ready,
	input  instr_t in_instr,
	// Retired records
	output logic   out_valid,
	input  logic   out_ready,
	output res_t   out_res
);

	logic iss_valid;
	logic iss_ready;
	uop_t iss_uop;
	logic exe_valid;
	logic exe_ready;
	res_t exe_res;

	// Front end, cracks and issues
	uop_sequencer u_uop_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.iss_valid (iss_valid),
		.iss_ready (iss_ready),
		.iss_uop   (iss_uop)
	);

	// Register file and arithmetic
	uop_alu u_uop_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.iss_valid (iss_valid),
		.iss_ready (iss_ready),
		.iss_uop   (iss_uop),
		.exe_valid (exe_valid),
		.exe_ready (exe_ready),
		.exe_res   (exe_res)
	);

	// Flags and output register
	uop_retire u_uop_retire (
		.clk       (clk),
		.rst_n     (rst_n),
		.exe_valid (exe_valid),
		.exe_ready (exe_ready),
		.exe_res   (exe_res),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res)
	);

endmodule

/* verif/uop_core_sva.sv */
// ==========================================================================
// Handshake and ordering assertions, bound into the core top level.
// ==========================================================================

module uop_core_sva import uop_pkg::*; (
	input logic   clk,
	input logic   rst_n,
	input logic   in_valid,
	input logic   in_ready,
	input instr_t in_instr,
	input logic   iss_valid,
	input logic   iss_ready,
	input uop_t   iss_uop,
	input logic   out_valid,
	input logic   out_ready,
	input res_t   out_res
);

	// Valid and payload hold until the transfer
	a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_instr))
		else $error("in_valid dropped or in_instr changed before transfer");

	a_iss_hold: assert property (@(posedge clk) disable iff (!rst_n)
		iss_valid && !iss_ready |=> iss_valid && $stable(iss_uop))
		else $error("iss_valid dropped or iss_uop changed before transfer");

	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_res))
		else $error("out_valid dropped or out_res changed before transfer");

	// Input stays closed until the entry marked last has issued
	a_busy: assert property (@(posedge clk) disable iff (!rst_n)
		iss_valid && !(iss_ready && iss_uop.last) |=> !in_ready)
		else $error("in_ready high while a list is held");

	a_reset: assert property (@(posedge clk) !rst_n |=> !iss_valid && !out_valid && in_ready)
		else $error("control outputs wrong after reset");

endmodule

bind uop_core uop_core_sva u_uop_core_sva (
	.clk       (clk),
	.rst_n     (rst_n),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.in_instr  (in_instr),
	.iss_valid (iss_valid),
	.iss_ready (iss_ready),
	.iss_uop   (iss_uop),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_res   (out_res)
);

/* verif/uop_core_tb.sv */
// ==========================================================================
// Directed testbench for the micro-op core. A register and flag model
// predicts every retired record, and a monitor checks them in order.
// ==========================================================================

module uop_core_tb import uop_pkg::*; ();

	localparam int TIMEOUT = 400;

	logic   clk;
	logic   rst_n;
	logic   in_valid;
	logic   in_ready;
	instr_t in_instr;
	logic   out_valid;
	logic   out_ready;
	res_t   out_res;

	// Model state and expected record queue
	logic [XLEN-1:0] mregs [NREGS];
	cr_t             mflags;
	res_t            exp_q [$];
	res_t            exp_r;
	res_t            last_res;
	logic [31:0]     stim_seed;
	logic [31:0]     bp_seed;
	logic [31:0]     bp_rand;
	logic            bp_en;
	int              bp_left;

	uop_core u_uop_core (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_instr  (in_instr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res)
	);

	always #4 clk = ~clk;

	// ======================================================================
	// Helpers
	// ======================================================================
	task automatic stop_on_error();
		$display("SOME TESTS FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_res(input string name, input res_t got, input res_t want);
		if (got !== want)
		begin
			$display("[FAIL] %0t %s got %h expected %h", $time, name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_flags(input string name, input cr_t got, input cr_t want);
		if (got !== want)
		begin
			$display("[FAIL] %0t %s got %b expected %b", $time, name, got, want);
			stop_on_error();
		end
	endtask

	// Halves swapped so the low bits are not the weak LCG bits
	function automatic logic [31:0] lcg_next(inout logic [31:0] state);
		state = state * 32'd1103515245 + 32'd12345;
		return {state[15:0], state[31:16]};
	endfunction

	function automatic logic [31:0] sext(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] carry_of(input logic [31:0] a, input logic [31:0] b);
		logic [32:0] s;
		s = {1'b0, a} + {1'b0, b};
		return {31'b0, s[32]};
	endfunction

	// Flag nibble is rec, cin, cout, imm_en
	function automatic instr_t make_instr(input op_e op, input logic [3:0] rd,
		input logic [3:0] rs1, input logic [3:0] rs2, input logic [3:0] flg,
		input logic [11:0] imm);
		instr_t i;
		i.opcode = op;
		i.rd = rd;
		i.rs1 = rs1;
		i.rs2 = rs2;
		{i.rec, i.cin, i.cout, i.imm_en} = flg;
		i.imm = imm;
		return i;
	endfunction

	// Random instruction on r0..r13 where multi also allows carry, rec, CMP and NOP
	function automatic instr_t rand_instr(input bit multi);
		op_e ops [9] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_MOV, OP_LDI,
			OP_CMP, OP_NOP};
		logic [31:0] r;
		int k;
		r = lcg_next(stim_seed);
		k = int'(r[31:28]) % (multi ? 9 : 7);
		return make_instr(ops[k], r[3:0] % 4'd14, r[7:4] % 4'd14, r[11:8] % 4'd14,
			{multi & r[25], multi & r[26], multi & r[27], r[24]}, r[23:12]);
	endfunction

	// ======================================================================
	// Reference model
	// ======================================================================
	function automatic logic [31:0] opb(input instr_t ins);
		return ins.imm_en ? sext(ins.imm) : mregs[ins.rs2];
	endfunction

	task automatic put(input uop_op_e op, input logic [3:0] rd, input logic wr,
		input logic [31:0] v);
		res_t r;
		r = '0;
		r.op = op;
		r.rd = rd;
		r.wr = wr;
		r.value = v;
		r.flags = mflags;
		if (wr)
			mregs[rd] = v;
		exp_q.push_back(r);
	endtask

	// Flags change before the compare record is stamped
	task automatic put_cmp(input logic [3:0] rd, input logic [31:0] a, input logic [31:0] b);
		mflags.lt = $signed(a) < $signed(b);
		mflags.eq = (a == b);
		mflags.gt = $signed(a) > $signed(b);
		put(UOP_CMP, rd, 1'b0, a - b);
	endtask

	task automatic model_instr(input instr_t ins);
		res_t r;
		case (ins.opcode)
			OP_ADD:
				if (ins.cin && ins.cout)
				begin
					put(UOP_ADD, TEMP_REG, 1'b1, mregs[ins.rs1] + mregs[CARRY_REG]);
					put(UOP_AGC, CARRY_REG, 1'b1, carry_of(mregs[ins.rs1], mregs[CARRY_REG]));
					put(UOP_AGCOR, CARRY_REG, 1'b1,
						mregs[CARRY_REG] | carry_of(mregs[TEMP_REG], opb(ins)));
					put(UOP_ADD, ins.rd, 1'b1, mregs[TEMP_REG] + opb(ins));
				end
				else if (ins.cin)
				begin
					put(UOP_ADD, TEMP_REG, 1'b1, mregs[ins.rs1] + mregs[CARRY_REG]);
					put(UOP_ADD, ins.rd, 1'b1, mregs[TEMP_REG] + opb(ins));
				end
				else if (ins.cout)
				begin
					put(UOP_AGC, CARRY_REG, 1'b1, carry_of(mregs[ins.rs1], opb(ins)));
					put(UOP_ADD, ins.rd, 1'b1, mregs[ins.rs1] + opb(ins));
				end
				else
					put(UOP_ADD, ins.rd, 1'b1, mregs[ins.rs1] + opb(ins));
			OP_SUB: put(UOP_SUB, ins.rd, 1'b1, mregs[ins.rs1] - opb(ins));
			OP_AND: put(UOP_AND, ins.rd, 1'b1, mregs[ins.rs1] & opb(ins));
			OP_OR:  put(UOP_OR, ins.rd, 1'b1, mregs[ins.rs1] | opb(ins));
			OP_XOR: put(UOP_XOR, ins.rd, 1'b1, mregs[ins.rs1] ^ opb(ins));
			OP_MOV: put(UOP_MOV, ins.rd, 1'b1, mregs[ins.rs1]);
			OP_LDI: put(UOP_MOV, ins.rd, 1'b1, sext(ins.imm));
			OP_CMP: put_cmp(ins.rd, mregs[ins.rs1], opb(ins));
			default: put(UOP_NOP, 4'd0, 1'b0, 32'd0);
		endcase
		// Record form on writing opcodes only
		if (ins.rec && ins.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_MOV, OP_LDI})
			put_cmp(ins.rd, mregs[ins.rd], 32'd0);
		r = exp_q.pop_back();
		r.last = 1'b1;
		exp_q.push_back(r);
	endtask

	// ======================================================================
	// Driver, monitor and output back-pressure
	// ======================================================================
	// Runs from just after a rising edge to just after the accepting edge
	task automatic send(input instr_t ins, output int waited, output int pending);
		int cyc;
		cyc = 0;
		in_instr = ins;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready)
		begin
			cyc++;
			if (cyc > TIMEOUT)
			begin
				$display("Timeout at %0t: instruction never accepted", $time);
				stop_on_error();
			end
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		waited = cyc;
		pending = exp_q.size();
		model_instr(ins);
	endtask

	task automatic drain();
		int cyc;
		cyc = 0;
		while (exp_q.size() != 0)
		begin
			@(negedge clk);
			cyc++;
			if (cyc > TIMEOUT)
			begin
				$display("Timeout at %0t: %0d records never retired", $time, exp_q.size());
				stop_on_error();
			end
		end
		@(posedge clk);
		#1;
	endtask

	always @(negedge clk)
	begin
		if (rst_n && out_valid && out_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("Unexpected record %h retired at %0t", out_res, $time);
				stop_on_error();
			end
			exp_r = exp_q.pop_front();
			check_flags("out_res.flags", out_res.flags, exp_r.flags);
			check_res("out_res", out_res, exp_r);
			last_res = out_res;
		end
	end

	// Random low stretches of out_ready
	always @(posedge clk)
	begin
		#1;
		if (!bp_en)
			out_ready = 1'b1;
		else if (bp_left > 0)
			bp_left = bp_left - 1;
		else
		begin
			bp_rand = lcg_next(bp_seed);
			out_ready = bp_rand[0];
			bp_left = int'(bp_rand[3:1]);
		end
	end

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic init_regs();
		int w;
		int p;
		for (int i = 0; i < NREGS; i++)
			send(make_instr(OP_LDI, 4'(i), 4'd0, 4'd0, 4'b0, 12'(lcg_next(stim_seed))), w, p);
		drain();
	endtask

	task automatic test_plain_ops();
		int w;
		int p;
		$display("Test: single micro-op instructions");
		for (int i = 0; i < 24; i++)
		begin
			send(rand_instr(1'b0), w, p);
			drain();
		end
	endtask

	task automatic test_carry();
		logic [33:0] s;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] want_c;
		logic [3:0]  flg;
		res_t        want;
		int          w;
		int          p;
		$display("Test: carry-in and carry-out chains");
		for (int k = 0; k < 9; k++)
		begin
			// All-ones rs1 with a set carry makes the first carry step produce 1
			send(make_instr(OP_LDI, CARRY_REG, 4'd0, 4'd0, 4'b0,
				(k < 3) ? 12'd1 : 12'(k & 1)), w, p);
			send(make_instr(OP_LDI, 4'd1, 4'd0, 4'd0, 4'b0,
				(k < 3) ? 12'hFFF : 12'(lcg_next(stim_seed))), w, p);
			send(make_instr(OP_LDI, 4'd2, 4'd0, 4'd0, 4'b0, 12'(lcg_next(stim_seed))), w, p);
			drain();
			a = mregs[1];
			b = mregs[2];
			c = mregs[CARRY_REG];
			s = {2'b0, a} + {2'b0, b} + {2'b0, c};
			case (k % 3)
				0:
				begin
					flg = 4'b0100;
					want_c = c;
				end
				1:
				begin
					flg = 4'b0010;
					want_c = carry_of(a, b);
				end
				default:
				begin
					flg = 4'b0110;
					want_c = {31'b0, s[32]};
				end
			endcase
			send(make_instr(OP_ADD, 4'd5, 4'd1, 4'd2, flg, 12'h0), w, p);
			send(make_instr(OP_MOV, 4'd6, CARRY_REG, 4'd0, 4'b0, 12'h0), w, p);
			drain();
			want = '0;
			want.op = UOP_MOV;
			want.rd = 4'd6;
			want.wr = 1'b1;
			want.value = want_c;
			want.flags = mflags;
			want.last = 1'b1;
			check_res("carry read from r14", last_res, want);
		end
	endtask

	task automatic flag_case(input instr_t ins, input cr_t want);
		int w;
		int p;
		send(ins, w, p);
		drain();
		check_flags("flags after compare", last_res.flags, want);
	endtask

	// Flag order is lt, eq, gt
	task automatic test_record();
		$display("Test: record compare");
		flag_case(make_instr(OP_LDI, 4'd3, 4'd0, 4'd0, 4'b1000, 12'hFFB), cr_t'(3'b100));
		flag_case(make_instr(OP_LDI, 4'd3, 4'd0, 4'd0, 4'b1000, 12'h000), cr_t'(3'b010));
		flag_case(make_instr(OP_LDI, 4'd3, 4'd0, 4'd0, 4'b1000, 12'h007), cr_t'(3'b001));
		flag_case(make_instr(OP_SUB, 4'd4, 4'd3, 4'd0, 4'b1001, 12'h009), cr_t'(3'b100));
		flag_case(make_instr(OP_ADD, 4'd4, 4'd3, 4'd3, 4'b1000, 12'h000), cr_t'(3'b001));
	endtask

	task automatic test_cmp_imm();
		logic [XLEN-1:0] snap [NREGS];
		res_t            want;
		int              w;
		int              p;
		$display("Test: compare with immediate");
		send(make_instr(OP_LDI, 4'd1, 4'd0, 4'd0, 4'b0, 12'd5), w, p);
		drain();
		snap = mregs;
		// rec on a compare appends nothing
		flag_case(make_instr(OP_CMP, 4'd0, 4'd1, 4'd0, 4'b1001, 12'd7), cr_t'(3'b100));
		flag_case(make_instr(OP_CMP, 4'd0, 4'd1, 4'd0, 4'b0001, 12'd5), cr_t'(3'b010));
		flag_case(make_instr(OP_CMP, 4'd0, 4'd1, 4'd0, 4'b0001, 12'hFFD), cr_t'(3'b001));
		for (int i = 0; i < 14; i++)
		begin
			send(make_instr(OP_MOV, 4'(i), 4'(i), 4'd0, 4'b0, 12'h0), w, p);
			drain();
			want = '0;
			want.op = UOP_MOV;
			want.rd = 4'(i);
			want.wr = 1'b1;
			want.value = snap[i];
			want.flags = mflags;
			want.last = 1'b1;
			check_res("register after compare", last_res, want);
		end
	endtask

	// Five micro-op list with out_ready high throughout
	task automatic test_input_hold();
		int w;
		int p;
		$display("Test: input held during a list");
		send(make_instr(OP_ADD, 4'd7, 4'd1, 4'd2, 4'b1110, 12'h0), w, p);
		send(make_instr(OP_LDI, 4'd8, 4'd0, 4'd0, 4'b0, 12'h123), w, p);
		if (w != 5 || p != 0)
		begin
			$display("Next instruction accepted after %0d cycles with %0d records left at %0t",
				w, p, $time);
			stop_on_error();
		end
		drain();
	endtask

	task automatic test_backpressure();
		int w;
		int p;
		$display("Test: back-to-back stream with output stalls");
		bp_en = 1'b1;
		for (int i = 0; i < 40; i++)
			send(rand_instr(1'b1), w, p);
		drain();
		bp_en = 1'b0;
	endtask

	initial
	begin
		clk = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_instr = '0;
		out_ready = 1'b1;
		bp_en = 1'b0;
		bp_left = 0;
		stim_seed = 32'd43939;
		bp_seed = 32'd43939;
		mflags = '0;
		last_res = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		init_regs();
		test_plain_ops();
		test_carry();
		test_record();
		test_cmp_imm();
		test_input_hold();
		test_backpressure();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* sources.f */
hw/uop_pkg.sv
hw/uop_expand.sv
hw/uop_sequencer.sv
hw/uop_alu.sv
hw/uop_retire.sv
hw/uop_core.sv
verif/uop_core_sva.sv
verif/uop_core_tb.sv

/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP       = uop_core_tb
FILELIST  = sources.f
BUILD     = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --Mdir $(BUILD) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)
